// ==== src/hero_config.svh ====
`ifndef HERO_CONFIG_SVH
`define HERO_CONFIG_SVH

// screen and floor geometry in pixels
`define HERO_POS_W         10
`define HERO_X_MAX         579    // 640 wide screen less the sprite width
`define HERO_FLOOR_Y       337    // start line and the only floor
`define HERO_Y_MIN         4      // ceiling

`define HERO_RUN_SPEED     3      // pixels per frame on the floor
`define HERO_AIR_SPEED     2      // sideways drift while airborne
`define HERO_FALL_SPEED    3

// jump arc, frame counts where each rise phase ends
`define HERO_JUMP_FAST_END 14
`define HERO_JUMP_MID_END  22
`define HERO_JUMP_LEN      30

`define HERO_LIFE_START    10
`define HERO_INVULN_FRAMES 128    // frames of immunity after a hit

`endif

// ==== src/hero_pkg.sv ====
`include "hero_config.svh"

package hero_pkg;

	typedef enum logic [1:0] {
		RUN,
		JUMP,
		FALL
	} hero_state_t;

	typedef enum logic [1:0] {
		RISE_FAST,
		RISE_MID,
		RISE_SLOW,
		DONE
	} jump_phase_t;

	typedef struct packed {
		logic left;
		logic right;
		logic jump;
		logic shoot;
	} keys_t;

	typedef struct packed {
		logic signed [7:0] vx;    // positive is right
		logic signed [7:0] vy;    // positive is down
	} motion_t;

	typedef struct packed {
		logic [`HERO_POS_W-1:0] x;
		logic [`HERO_POS_W-1:0] y;
	} pos_t;

	typedef struct packed {
		hero_state_t state;
		logic        facing;    // 1 is right
		logic        shoot;
		logic        moving;    // nonzero vx this frame
	} pose_t;

	typedef logic [4:0] sprite_code_t;

endpackage

// ==== src/frame_tick_fsm.sv ====
`timescale 1ns/100ps
`include "hero_config.svh"

module frame_tick_fsm (
	input  logic                  Clk,
	input  logic                  arst_n,
	input  logic                  frame_clk,
	input  hero_pkg::keys_t       keys,
	input  hero_pkg::jump_phase_t jump_phase,
	input  logic                  on_floor,
	input  logic                  top_hit,
	input  logic                  restart,
	output logic                  frame_tick,
	output logic                  jump_start,
	output hero_pkg::motion_t     motion,
	output hero_pkg::pose_t       pose
);

	logic [1:0]            frame_sync;    // two stage capture of frame_clk
	hero_pkg::hero_state_t state_q;
	hero_pkg::hero_state_t state_n;
	logic                  facing_q;
	logic                  facing_n;
	logic                  right_only;
	logic                  left_only;
	logic signed [7:0]     speed;

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			frame_sync <= '0;
			frame_tick <= 1'b0;
		end
		else
		begin
			frame_sync <= {frame_sync[0], frame_clk};
			frame_tick <= frame_sync[0] & ~frame_sync[1];    // rising edge, one cycle
		end
	end

	assign right_only = keys.right & ~keys.left;
	assign left_only  = keys.left & ~keys.right;
	assign speed      = (state_q == hero_pkg::RUN) ? 8'(`HERO_RUN_SPEED) : 8'(`HERO_AIR_SPEED);

	always_comb
	begin
		state_n    = state_q;
		facing_n   = facing_q;
		jump_start = 1'b0;
		motion.vx  = 8'sd0;    // both or neither key
		motion.vy  = 8'sd0;
		if (right_only)
		begin
			facing_n  = 1'b1;
			motion.vx = speed;
		end
		else if (left_only)
		begin
			facing_n  = 1'b0;
			motion.vx = -speed;
		end
		case (state_q)
			hero_pkg::RUN:
			begin
				if (keys.jump)
				begin
					state_n    = hero_pkg::JUMP;
					jump_start = frame_tick;
				end
			end
			hero_pkg::JUMP:
			begin
				case (jump_phase)
					hero_pkg::RISE_FAST: motion.vy = -8'sd4;
					hero_pkg::RISE_MID:  motion.vy = -8'sd2;
					hero_pkg::RISE_SLOW: motion.vy = -8'sd1;
					default:             motion.vy = 8'sd0;    // apex frame
				endcase
				if (jump_phase == hero_pkg::DONE || top_hit)
					state_n = hero_pkg::FALL;
			end
			hero_pkg::FALL:
			begin
				motion.vy = 8'(`HERO_FALL_SPEED);
				if (on_floor)
					state_n = hero_pkg::RUN;
			end
			default: state_n = hero_pkg::RUN;
		endcase
	end

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q  <= hero_pkg::RUN;
			facing_q <= 1'b1;
		end
		else if (restart)
		begin
			state_q  <= hero_pkg::RUN;
			facing_q <= 1'b1;
		end
		else if (frame_tick)
		begin
			state_q  <= state_n;
			facing_q <= facing_n;
		end
	end

	assign pose.state  = state_q;
	assign pose.facing = facing_n;    // new facing shows on this frame's sprite
	assign pose.shoot  = keys.shoot;
	assign pose.moving = (motion.vx != 8'sd0);

	// a jump launches only on a frame tick
	jump_start_on_tick: assert property (@(posedge Clk) disable iff (!arst_n)
		jump_start |-> frame_tick);

endmodule

// ==== src/jump_timer.sv ====
`timescale 1ns/100ps
`include "hero_config.svh"

module jump_timer (
	input  logic                  Clk,
	input  logic                  arst_n,
	input  logic                  frame_tick,
	input  logic                  jump_start,
	input  logic                  restart,
	output hero_pkg::jump_phase_t jump_phase
);

	logic [$clog2(`HERO_JUMP_LEN+1)-1:0] cnt_q;    // frames since launch

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
			cnt_q <= '0;
		else if (restart || jump_start)
			cnt_q <= '0;
		else if (frame_tick && cnt_q < `HERO_JUMP_LEN)
			cnt_q <= cnt_q + 1'b1;    // saturates at the arc length
	end

	always_comb
	begin
		if (cnt_q < `HERO_JUMP_FAST_END)
			jump_phase = hero_pkg::RISE_FAST;
		else if (cnt_q < `HERO_JUMP_MID_END)
			jump_phase = hero_pkg::RISE_MID;
		else if (cnt_q < `HERO_JUMP_LEN)
			jump_phase = hero_pkg::RISE_SLOW;
		else
			jump_phase = hero_pkg::DONE;
	end

	cnt_in_range: assert property (@(posedge Clk) disable iff (!arst_n)
		cnt_q <= `HERO_JUMP_LEN);

endmodule

// ==== src/pos_integrator.sv ====
`timescale 1ns/100ps
`include "hero_config.svh"

module pos_integrator (
	input  logic              Clk,
	input  logic              arst_n,
	input  logic              frame_tick,
	input  logic              restart,
	input  hero_pkg::motion_t motion,
	output hero_pkg::pos_t    pos,
	output logic              on_floor,
	output logic              top_hit
);

	logic signed [`HERO_POS_W+1:0] nx;    // two spare bits hold sign and overflow
	logic signed [`HERO_POS_W+1:0] ny;
	hero_pkg::pos_t                pos_n;

	always_comb
	begin
		nx      = $signed({2'b00, pos.x}) + motion.vx;
		ny      = $signed({2'b00, pos.y}) + motion.vy;
		pos_n.x = nx[`HERO_POS_W-1:0];
		pos_n.y = ny[`HERO_POS_W-1:0];
		if (nx < 0)
			pos_n.x = '0;    // left edge
		else if (nx > `HERO_X_MAX)
			pos_n.x = `HERO_POS_W'(`HERO_X_MAX);
		if (ny < `HERO_Y_MIN)
			pos_n.y = `HERO_POS_W'(`HERO_Y_MIN);
		else if (ny > `HERO_FLOOR_Y)
			pos_n.y = `HERO_POS_W'(`HERO_FLOOR_Y);
	end

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pos.x    <= '0;
			pos.y    <= `HERO_POS_W'(`HERO_FLOOR_Y);
			on_floor <= 1'b1;
			top_hit  <= 1'b0;
		end
		else if (restart)
		begin
			pos.x    <= '0;    // back to the start spot
			pos.y    <= `HERO_POS_W'(`HERO_FLOOR_Y);
			on_floor <= 1'b1;
			top_hit  <= 1'b0;
		end
		else if (frame_tick)
		begin
			pos      <= pos_n;
			on_floor <= (ny >= `HERO_FLOOR_Y);
			top_hit  <= (ny <= `HERO_Y_MIN);    // head reached the ceiling
		end
	end

	above_floor: assert property (@(posedge Clk) disable iff (!arst_n)
		pos.y <= `HERO_FLOOR_Y);

endmodule

// ==== src/sprite_picker.sv ====
`timescale 1ns/100ps

module sprite_picker (
	input  logic                   Clk,
	input  logic                   arst_n,
	input  logic                   frame_tick,
	input  hero_pkg::pose_t        pose,
	output hero_pkg::sprite_code_t sprite
);

	logic [3:0]             step_q;    // run animation, msb picks the stride
	hero_pkg::sprite_code_t sprite_n;

	always_comb
	begin
		if (pose.state != hero_pkg::RUN)
		begin
			if (pose.facing)
				sprite_n = pose.shoot ? 5'd13 : 5'd8;
			else
				sprite_n = pose.shoot ? 5'd12 : 5'd7;
		end
		else if (!pose.moving)
		begin
			if (pose.facing)
				sprite_n = pose.shoot ? 5'd14 : 5'd0;    // standing right
			else
				sprite_n = pose.shoot ? 5'd15 : 5'd1;
		end
		else if (pose.facing)
		begin
			if (step_q[3])
				sprite_n = pose.shoot ? 5'd18 : 5'd3;
			else
				sprite_n = pose.shoot ? 5'd17 : 5'd2;
		end
		else
		begin
			if (step_q[3])
				sprite_n = pose.shoot ? 5'd16 : 5'd6;
			else
				sprite_n = pose.shoot ? 5'd11 : 5'd4;
		end
	end

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			step_q <= '0;
			sprite <= '0;
		end
		else if (frame_tick)
		begin
			sprite <= sprite_n;
			if (pose.state == hero_pkg::RUN && pose.moving)
				step_q <= step_q + 1'b1;
			else
				step_q <= '0;    // stride restarts from the first frame
		end
	end

endmodule

// ==== src/life_tracker.sv ====
`timescale 1ns/100ps
`include "hero_config.svh"

module life_tracker (
	input  logic       Clk,
	input  logic       arst_n,
	input  logic       frame_tick,
	input  logic       damage,
	output logic [7:0] life,
	output logic       dead,
	output logic       restart
);

	logic [$clog2(`HERO_INVULN_FRAMES+1)-1:0] win_q;    // frames left of immunity
	logic                                     pending_q;    // hit seen since last tick
	logic                                     dead_q;

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			life      <= 8'(`HERO_LIFE_START);
			win_q     <= '0;
			pending_q <= 1'b0;
			dead_q    <= 1'b0;
		end
		else
		begin
			dead_q <= frame_tick && (life == 8'd0);
			if (dead_q)
			begin
				life      <= 8'(`HERO_LIFE_START);    // fresh hero
				win_q     <= '0;
				pending_q <= 1'b0;
			end
			else if (frame_tick)
			begin
				pending_q <= 1'b0;
				if (win_q != '0)
					win_q <= win_q - 1'b1;
				else if ((pending_q || damage) && life != 8'd0)
				begin
					life  <= life - 8'd1;
					win_q <= $bits(win_q)'(`HERO_INVULN_FRAMES);
				end
			end
			else if (damage && win_q == '0)
				pending_q <= 1'b1;    // hits inside the window are ignored
		end
	end

	assign dead    = dead_q;
	assign restart = dead_q;

endmodule

// ==== src/hero_ctrl.sv ====
`timescale 1ns/100ps

module hero_ctrl (
	input  logic                   Clk,
	input  logic                   arst_n,
	input  logic                   frame_clk,
	input  hero_pkg::keys_t        keys,
	input  logic                   damage,
	output hero_pkg::pos_t         pos,
	output hero_pkg::sprite_code_t sprite,
	output logic [7:0]             life,
	output logic                   dead
);

	logic                  frame_tick;
	logic                  jump_start;
	logic                  on_floor;
	logic                  top_hit;
	logic                  restart;
	hero_pkg::jump_phase_t jump_phase;
	hero_pkg::motion_t     motion;
	hero_pkg::pose_t       pose;

	frame_tick_fsm frame_tick_fsm_i (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.frame_clk  (frame_clk),
		.keys       (keys),
		.jump_phase (jump_phase),
		.on_floor   (on_floor),
		.top_hit    (top_hit),
		.restart    (restart),
		.frame_tick (frame_tick),
		.jump_start (jump_start),
		.motion     (motion),
		.pose       (pose)
	);

	jump_timer jump_timer_i (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.jump_start (jump_start),
		.restart    (restart),
		.jump_phase (jump_phase)
	);

	pos_integrator pos_integrator_i (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.restart    (restart),
		.motion     (motion),
		.pos        (pos),
		.on_floor   (on_floor),
		.top_hit    (top_hit)
	);

	sprite_picker sprite_picker_i (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.pose       (pose),
		.sprite     (sprite)
	);

	life_tracker life_tracker_i (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.damage     (damage),
		.life       (life),
		.dead       (dead),
		.restart    (restart)    // same pulse as dead
	);

endmodule

// ==== sim/hero_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "hero_config.svh"

module hero_ctrl_tb;

	localparam int MAX_ROWS = 32;

	logic                   Clk;
	logic                   arst_n;
	logic                   frame_clk;
	hero_pkg::keys_t        keys;
	logic                   damage;
	hero_pkg::pos_t         pos;
	hero_pkg::sprite_code_t sprite;
	logic [7:0]             life;
	logic                   dead;

	string                  row_name [MAX_ROWS];
	hero_pkg::keys_t        row_keys [MAX_ROWS];
	bit                     row_hit [MAX_ROWS];    // strobe in the first frame only
	int                     row_frames [MAX_ROWS];
	hero_pkg::pos_t         exp_pos [MAX_ROWS];
	hero_pkg::sprite_code_t exp_sprite [MAX_ROWS];
	logic [7:0]             exp_life [MAX_ROWS];
	bit                     exp_dead [MAX_ROWS];
	int                     n_rows = 0;

	// reference model of the hero, one call per frame
	int                     m_x;
	int                     m_y;
	int                     m_cnt;
	int                     m_step;
	int                     m_life;
	int                     m_win;
	bit                     m_facing;
	bit                     m_pend;
	bit                     m_floor;
	bit                     m_top;
	bit                     m_dead;
	hero_pkg::hero_state_t  m_state;
	hero_pkg::sprite_code_t m_sprite;

	// pairs of plain and shooting codes per pose
	hero_pkg::sprite_code_t sprite_table [16] = '{5'd0, 5'd14, 5'd1, 5'd15, 5'd2, 5'd17,
		5'd3, 5'd18, 5'd4, 5'd11, 5'd6, 5'd16, 5'd8, 5'd13, 5'd7, 5'd12};

	hero_pkg::pos_t         mid_pos;
	hero_pkg::sprite_code_t mid_sprite;
	logic [7:0]             mid_life;
	int                     err_count = 0;
	int                     dead_count = 0;
	int                     cycle_count = 0;
	int                     cycle_limit = 0;
	int                     n_pass = 0;
	int                     errs_before;
	int                     deads_before;

	hero_ctrl hero_ctrl_i (
		.Clk       (Clk),
		.arst_n    (arst_n),
		.frame_clk (frame_clk),
		.keys      (keys),
		.damage    (damage),
		.pos       (pos),
		.sprite    (sprite),
		.life      (life),
		.dead      (dead)
	);

	function automatic hero_pkg::sprite_code_t expected_sprite(input bit air, input bit right,
		input bit shoot, input bit moving, input bit stride);
		int pose_idx;
		if (air)
			pose_idx = right ? 6 : 7;
		else if (!moving)
			pose_idx = right ? 0 : 1;
		else
			pose_idx = (right ? 2 : 4) + (stride ? 1 : 0);
		return sprite_table[pose_idx * 2 + (shoot ? 1 : 0)];
	endfunction

	task automatic restart_model();
		m_x      = 0;
		m_y      = `HERO_FLOOR_Y;
		m_floor  = 1'b1;
		m_top    = 1'b0;
		m_state  = hero_pkg::RUN;
		m_facing = 1'b1;
		m_cnt    = 0;
		m_life   = `HERO_LIFE_START;
		m_win    = 0;
		m_pend   = 1'b0;
	endtask

	task automatic step_model(input hero_pkg::keys_t k, input bit hit);
		int                    vx;
		int                    vy;
		int                    ny;
		bit                    die;
		hero_pkg::hero_state_t nxt;
		die = (m_life == 0);    // a tick with no life left
		if (hit && m_win == 0)
			m_pend = 1'b1;
		if (m_win != 0)
			m_win--;
		else if (m_pend && m_life != 0)
		begin
			m_life--;
			m_win = `HERO_INVULN_FRAMES;
		end
		m_pend = 1'b0;
		vx     = 0;
		vy     = 0;
		nxt    = m_state;
		if (k.right != k.left)
		begin
			vx       = (m_state == hero_pkg::RUN) ? `HERO_RUN_SPEED : `HERO_AIR_SPEED;
			vx       = k.right ? vx : -vx;
			m_facing = k.right;
		end
		if (m_state == hero_pkg::JUMP)
		begin
			vy = (m_cnt < `HERO_JUMP_FAST_END) ? -4 : (m_cnt < `HERO_JUMP_MID_END) ? -2 :
				(m_cnt < `HERO_JUMP_LEN) ? -1 : 0;
			if (m_cnt >= `HERO_JUMP_LEN || m_top)
				nxt = hero_pkg::FALL;
		end
		else if (m_state == hero_pkg::FALL)
		begin
			vy = `HERO_FALL_SPEED;
			if (m_floor)
				nxt = hero_pkg::RUN;
		end
		else if (k.jump)
			nxt = hero_pkg::JUMP;
		m_sprite = expected_sprite(m_state != hero_pkg::RUN, m_facing, k.shoot, vx != 0, m_step >= 8);
		m_step   = (m_state == hero_pkg::RUN && vx != 0) ? (m_step + 1) % 16 : 0;
		if (m_state == hero_pkg::RUN && k.jump)
			m_cnt = 0;
		else if (m_cnt < `HERO_JUMP_LEN)
			m_cnt++;
		m_x = m_x + vx;
		if (m_x < 0)
			m_x = 0;
		else if (m_x > `HERO_X_MAX)
			m_x = `HERO_X_MAX;
		ny      = m_y + vy;
		m_floor = (ny >= `HERO_FLOOR_Y);
		m_top   = (ny <= `HERO_Y_MIN);
		m_y     = (ny > `HERO_FLOOR_Y) ? `HERO_FLOOR_Y : (ny < `HERO_Y_MIN) ? `HERO_Y_MIN : ny;
		m_state = nxt;
		if (die)
		begin
			restart_model();    // sprite and run step keep their values
			m_dead = 1'b1;
		end
	endtask

	task automatic add_row(input string name, input hero_pkg::keys_t k, input bit hit,
		input int frames);
		m_dead = 1'b0;
		for (int f = 0; f < frames; f++)
			step_model(k, hit && f == 0);
		row_name[n_rows]   = name;
		row_keys[n_rows]   = k;
		row_hit[n_rows]    = hit;
		row_frames[n_rows] = frames;
		exp_pos[n_rows].x  = `HERO_POS_W'(m_x);
		exp_pos[n_rows].y  = `HERO_POS_W'(m_y);
		exp_sprite[n_rows] = m_sprite;
		exp_life[n_rows]   = 8'(m_life);
		exp_dead[n_rows]   = m_dead;
		n_rows++;
	endtask

	task automatic build_table();
		restart_model();
		m_step   = 0;
		m_sprite = '0;
		add_row("reset", 4'b0000, 1'b0, 1);    // keys are left, right, jump, shoot
		add_row("run_right", 4'b0100, 1'b0, 20);
		add_row("run_right_shoot", 4'b0101, 1'b0, 5);
		add_row("run_left", 4'b1000, 1'b0, 10);
		add_row("run_left_shoot", 4'b1001, 1'b0, 3);
		add_row("stand_left", 4'b0000, 1'b0, 2);
		add_row("stand_left_shoot", 4'b0001, 1'b0, 1);
		add_row("right_edge", 4'b0100, 1'b0, 200);
		add_row("stand_right_shoot", 4'b0001, 1'b0, 1);
		add_row("left_edge", 4'b1000, 1'b0, 200);
		add_row("jump", 4'b0010, 1'b0, 1);
		add_row("rise_shoot", 4'b0001, 1'b0, 30);
		add_row("fall_right", 4'b0100, 1'b0, 28);
		add_row("hit", 4'b0000, 1'b1, 1);
		add_row("hit_in_window", 4'b0000, 1'b1, 100);
		add_row("window_close", 4'b0000, 1'b0, 40);
		add_row("hit_after_window", 4'b0000, 1'b1, 129);
		for (int i = 1; i <= 8; i++)
			add_row($sformatf("drain_%0d", i), 4'b0000, 1'b1, 129);
		cycle_limit = 200;
		for (int r = 0; r < n_rows; r++)
			cycle_limit += 16 * row_frames[r];
	endtask

	// one frame of 16 cycles, outputs sampled mid-frame
	task automatic run_frame(input hero_pkg::keys_t k, input bit hit);
		@(posedge Clk);
		frame_clk <= 1'b1;
		keys      <= k;
		damage    <= hit;
		@(posedge Clk);
		damage <= 1'b0;
		repeat (7) @(posedge Clk);
		mid_pos    = pos;
		mid_sprite = sprite;
		mid_life   = life;
		frame_clk <= 1'b0;
		repeat (7) @(posedge Clk);
	endtask

	task automatic check_pos(input string name, input hero_pkg::pos_t exp, input hero_pkg::pos_t act);
		if (act !== exp)
		begin
			$display("Fail %s pos expected (%0d,%0d) actual (%0d,%0d)", name, exp.x, exp.y,
				act.x, act.y);
			err_count++;
		end
	endtask

	task automatic check_sprite(input string name, input hero_pkg::sprite_code_t exp,
		input hero_pkg::sprite_code_t act);
		if (act !== exp)
		begin
			$display("Fail %s sprite expected %0d actual %0d", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_life(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("Fail %s life expected %0d actual %0d", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_dead(input string name, input bit exp, input bit act);
		if (act != exp)
		begin
			$display("Fail %s dead pulse seen expected %0d actual %0d", name, exp, act);
			err_count++;
		end
	endtask

	initial
	begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	always @(posedge Clk)
	begin
		if (dead === 1'b1)
			dead_count++;
	end

	initial
	begin
		@(posedge Clk);
		while (cycle_count < cycle_limit)
		begin
			@(posedge Clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycle_count);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		arst_n    = 1'b0;
		frame_clk = 1'b0;
		keys      = '0;
		damage    = 1'b0;
		build_table();
		repeat (16) @(posedge Clk);
		arst_n <= 1'b1;
		for (int r = 0; r < n_rows; r++)
		begin
			errs_before  = err_count;
			deads_before = dead_count;
			for (int f = 0; f < row_frames[r]; f++)
				run_frame(row_keys[r], row_hit[r] && f == 0);
			check_pos(row_name[r], exp_pos[r], mid_pos);
			check_sprite(row_name[r], exp_sprite[r], mid_sprite);
			check_life(row_name[r], exp_life[r], mid_life);
			check_dead(row_name[r], exp_dead[r], dead_count != deads_before);
			if (err_count == errs_before)
				n_pass++;
			$display("%-18s %s", row_name[r], (err_count == errs_before) ? "passed" : "failed");
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", n_rows, n_pass,
			n_rows - n_pass, err_count);
		if (err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+src
src/hero_pkg.sv
src/frame_tick_fsm.sv
src/jump_timer.sv
src/pos_integrator.sv
src/sprite_picker.sv
src/life_tracker.sv
src/hero_ctrl.sv
sim/hero_ctrl_tb.sv

// ==== Makefile ====
TOP = hero_ctrl_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
